// ==== src/cpu_isa_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction set of the 16-bit pipelined core
// word and field types, opcodes and bit positions in the instruction word
////////////////////////////////////////////////////////////////////////////
package cpu_isa_pkg;

   // data and address word
   typedef logic [15:0] word_t;
   typedef logic [3:0]  reg_addr_t;
   typedef logic [7:0]  imm8_t;

   // kept opcodes, any other code runs as a no-op
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_NOR  = 4'd3,
      OP_ADDI = 4'd4,
      OP_LW   = 4'd8,
      OP_SW   = 4'd9,
      OP_LHB  = 4'd10,
      OP_LLB  = 4'd11,
      OP_HLT  = 4'd15
   } opcode_t;

   // lw and sw always address off r14
   localparam reg_addr_t BASE_REG = 4'd14;
   localparam int NUM_REGS = 16;

   // field positions
   localparam int OPC_MSB  = 15;
   localparam int OPC_LSB  = 12;
   localparam int RD_MSB   = 11;
   localparam int RD_LSB   = 8;
   localparam int RS_MSB   = 7;
   localparam int RS_LSB   = 4;
   // rt and imm4 share the low nibble
   localparam int RT_MSB   = 3;
   localparam int RT_LSB   = 0;
   localparam int IMM8_MSB = 7;
   localparam int IMM8_LSB = 0;

endpackage

// ==== src/cpu_pipe_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// pipeline types of the core
// writeback source, alu operation and the ID/EX stage register
////////////////////////////////////////////////////////////////////////////
package cpu_pipe_pkg;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_BYTE} wb_src_t;

   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_NOR} alu_op_t;

   // id/ex entry, control bits first
   typedef struct packed {
      logic                   valid;
      logic                   reg_we;
      logic                   mem_we;
      logic                   mem_re;
      logic                   use_imm;
      logic                   halt;
      // lhb when set, llb otherwise
      logic                   high_byte;
      alu_op_t                alu_op;
      wb_src_t                wb_src;
      cpu_isa_pkg::reg_addr_t rd;
      cpu_isa_pkg::word_t     op_a;
      cpu_isa_pkg::word_t     op_b;
      cpu_isa_pkg::word_t     imm;
      cpu_isa_pkg::word_t     store_data;
   } id_ex_t;

endpackage

// ==== src/ex_mem_if.sv ====
////////////////////////////////////////////////////////////////////////////
// EX/MEM stage register bundle
// full view for writeback, reduced view for the decode hazard check
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface ex_mem_if;
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   logic      reg_we;
   logic      mem_re;
   logic      halt;
   reg_addr_t rd;
   wb_src_t   wb_src;
   word_t     alu_out;
   word_t     byte_data;

   modport execute (output reg_we, mem_re, halt, rd, wb_src, alu_out, byte_data);
   modport writeback (input reg_we, mem_re, halt, rd, wb_src, alu_out, byte_data);
   // only the pending write is needed to stall
   modport hazard (input reg_we, rd);

endinterface

// ==== src/fetch_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch unit
// program counter and IF/ID instruction register, held on stall and halt
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_unit (
   input  logic               clk,
   input  logic               rst,
   input  cpu_isa_pkg::word_t instr,
   input  logic               stall,
   input  logic               halt_seen,
   output cpu_isa_pkg::word_t pc,
   output cpu_isa_pkg::word_t if_instr,
   output logic               if_valid
);

   logic advance;

   // hlt stays in IF/ID, so halt_seen stays up and fetch stays frozen
   assign advance = !stall && !halt_seen;

   // pc and valid flag
   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= 16'd0;
         if_valid <= 1'b0;
      end else if (advance) begin
         pc       <= pc + 16'd1;
         if_valid <= 1'b1;
      end
   end

   // instruction word, sampled with the pc it came from
   always_ff @(posedge clk) begin
      if (advance) begin
         if_instr <= instr;
      end
   end

endmodule

// ==== src/decode_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// decode stage
// opcode decode, raw hazard stall, register read and the ID/EX register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage (
   input  logic                   clk,
   input  logic                   rst,
   input  cpu_isa_pkg::word_t     if_instr,
   input  logic                   if_valid,
   ex_mem_if.hazard               ex_mem,
   output cpu_isa_pkg::reg_addr_t rd_addr_a,
   output cpu_isa_pkg::reg_addr_t rd_addr_b,
   input  cpu_isa_pkg::word_t     rd_data_a,
   input  cpu_isa_pkg::word_t     rd_data_b,
   output logic                   stall,
   output logic                   halt_seen,
   output cpu_pipe_pkg::id_ex_t   id_ex
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   opcode_t   opc;
   reg_addr_t rd;
   reg_addr_t rs;
   reg_addr_t rt;
   imm8_t     imm8;
   logic      uses_a;
   logic      uses_b;
   logic      hit_a;
   logic      hit_b;
   logic      load;
   logic      halt_q;
   id_ex_t    nxt;

   // fields
   assign opc  = opcode_t'(if_instr[OPC_MSB:OPC_LSB]);
   assign rd   = if_instr[RD_MSB:RD_LSB];
   assign rs   = if_instr[RS_MSB:RS_LSB];
   assign rt   = if_instr[RT_MSB:RT_LSB];
   assign imm8 = if_instr[IMM8_MSB:IMM8_LSB];

   // read port select and which ports are live
   always_comb begin
      rd_addr_a = rs;
      rd_addr_b = rt;
      uses_a    = 1'b0;
      uses_b    = 1'b0;
      case (opc)
         OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
            uses_a = 1'b1;
            uses_b = 1'b1;
         end
         OP_ADDI: uses_a = 1'b1;
         OP_LW: begin
            rd_addr_a = BASE_REG;
            uses_a    = 1'b1;
         end
         // store data comes from rd
         OP_SW: begin
            rd_addr_a = BASE_REG;
            rd_addr_b = rd;
            uses_a    = 1'b1;
            uses_b    = 1'b1;
         end
         // byte loads keep the other byte of rd
         OP_LHB, OP_LLB: begin
            rd_addr_b = rd;
            uses_b    = 1'b1;
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // hazard check
   ////////////////////////////////////////////////////////////////////////////
   // mem/wb needs no check, the register file writes through
   assign hit_a = uses_a && ((id_ex.valid && id_ex.reg_we && id_ex.rd == rd_addr_a) ||
                             (ex_mem.reg_we && ex_mem.rd == rd_addr_a));
   assign hit_b = uses_b && ((id_ex.valid && id_ex.reg_we && id_ex.rd == rd_addr_b) ||
                             (ex_mem.reg_we && ex_mem.rd == rd_addr_b));

   assign stall     = if_valid && !halt_q && (hit_a || hit_b);
   assign halt_seen = if_valid && (opc == OP_HLT);
   assign load      = if_valid && !halt_q && !stall;

   // hlt goes down the pipe once, bubbles after it
   always_ff @(posedge clk) begin
      if (rst) begin
         halt_q <= 1'b0;
      end else if (load && opc == OP_HLT) begin
         halt_q <= 1'b1;
      end
   end

   // control decode
   always_comb begin
      nxt            = '0;
      nxt.rd         = rd;
      nxt.op_a       = rd_data_a;
      nxt.op_b       = rd_data_b;
      nxt.store_data = rd_data_b;
      // imm4 only for addi, byte loads use the low eight bits
      nxt.imm        = (opc == OP_ADDI) ? {{12{if_instr[RT_MSB]}}, if_instr[RT_MSB:RT_LSB]}
                                        : {{8{imm8[7]}}, imm8};
      nxt.alu_op     = ALU_ADD;
      nxt.wb_src     = WB_ALU;
      case (opc)
         OP_ADD: nxt.reg_we = 1'b1;
         OP_SUB: begin
            nxt.reg_we = 1'b1;
            nxt.alu_op = ALU_SUB;
         end
         OP_AND: begin
            nxt.reg_we = 1'b1;
            nxt.alu_op = ALU_AND;
         end
         OP_NOR: begin
            nxt.reg_we = 1'b1;
            nxt.alu_op = ALU_NOR;
         end
         OP_ADDI: begin
            nxt.reg_we  = 1'b1;
            nxt.use_imm = 1'b1;
         end
         OP_LW: begin
            nxt.reg_we  = 1'b1;
            nxt.mem_re  = 1'b1;
            nxt.use_imm = 1'b1;
            nxt.wb_src  = WB_MEM;
         end
         OP_SW: begin
            nxt.mem_we  = 1'b1;
            nxt.use_imm = 1'b1;
         end
         OP_LHB: begin
            nxt.reg_we    = 1'b1;
            nxt.wb_src    = WB_BYTE;
            nxt.high_byte = 1'b1;
         end
         OP_LLB: begin
            nxt.reg_we = 1'b1;
            nxt.wb_src = WB_BYTE;
         end
         OP_HLT: nxt.halt = 1'b1;
         default: ;
      endcase
      // bubble on stall, after halt, or with nothing fetched yet
      nxt.valid = load;
      if (!load) begin
         nxt.reg_we = 1'b0;
         nxt.mem_we = 1'b0;
         nxt.mem_re = 1'b0;
         nxt.halt   = 1'b0;
      end
   end

   // id/ex register
   always_ff @(posedge clk) begin
      if (rst) begin
         id_ex.valid  <= 1'b0;
         id_ex.reg_we <= 1'b0;
         id_ex.mem_we <= 1'b0;
         id_ex.mem_re <= 1'b0;
         id_ex.halt   <= 1'b0;
      end else begin
         id_ex <= nxt;
      end
   end

endmodule

// ==== src/reg_file.sv ====
////////////////////////////////////////////////////////////////////////////
// register file
// sixteen 16-bit registers, two read ports with write-through
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file (
   input  logic                   clk,
   input  logic                   rst,
   input  cpu_isa_pkg::reg_addr_t rd_addr_a,
   input  cpu_isa_pkg::reg_addr_t rd_addr_b,
   output cpu_isa_pkg::word_t     rd_data_a,
   output cpu_isa_pkg::word_t     rd_data_b,
   input  logic                   we,
   input  cpu_isa_pkg::reg_addr_t waddr,
   input  cpu_isa_pkg::word_t     wdata
);
   import cpu_isa_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // same-cycle write wins so decode sees the mem/wb result
   assign rd_data_a = (we && waddr == rd_addr_a) ? wdata : regs[rd_addr_a];
   assign rd_data_b = (we && waddr == rd_addr_b) ? wdata : regs[rd_addr_b];

endmodule

// ==== src/execute_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// execute stage
// operand select, alu, byte merge and the EX/MEM register with mem strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage (
   input  logic                 clk,
   input  logic                 rst,
   input  cpu_pipe_pkg::id_ex_t id_ex,
   ex_mem_if.execute            ex_mem,
   output cpu_isa_pkg::word_t   dm_addr,
   output cpu_isa_pkg::word_t   dm_wdata,
   output logic                 dm_we,
   output logic                 dm_re
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   word_t alu_b;
   word_t alu_y;
   word_t merged;
   imm8_t imm8;

   // second operand
   assign alu_b = id_ex.use_imm ? id_ex.imm : id_ex.op_b;

   always_comb begin
      alu_y = id_ex.op_a + alu_b;
      case (id_ex.alu_op)
         ALU_SUB: alu_y = id_ex.op_a - alu_b;
         ALU_AND: alu_y = id_ex.op_a & alu_b;
         ALU_NOR: alu_y = ~(id_ex.op_a | alu_b);
         default: ;
      endcase
   end

   // lhb replaces the high byte, llb the low byte
   assign imm8   = id_ex.imm[7:0];
   assign merged = id_ex.high_byte ? {imm8, id_ex.op_b[7:0]} : {id_ex.op_b[15:8], imm8};

   ////////////////////////////////////////////////////////////////////////////
   // ex/mem register
   ////////////////////////////////////////////////////////////////////////////
   // control, dropped for bubbles
   always_ff @(posedge clk) begin
      if (rst) begin
         ex_mem.reg_we <= 1'b0;
         ex_mem.mem_re <= 1'b0;
         ex_mem.halt   <= 1'b0;
         dm_we         <= 1'b0;
      end else begin
         ex_mem.reg_we <= id_ex.valid && id_ex.reg_we;
         ex_mem.mem_re <= id_ex.valid && id_ex.mem_re;
         ex_mem.halt   <= id_ex.valid && id_ex.halt;
         dm_we         <= id_ex.valid && id_ex.mem_we;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      ex_mem.rd        <= id_ex.rd;
      ex_mem.wb_src    <= id_ex.wb_src;
      ex_mem.alu_out   <= alu_y;
      ex_mem.byte_data <= merged;
      dm_wdata         <= id_ex.store_data;
   end

   // alu sum doubles as the data address
   assign dm_addr = ex_mem.alu_out;
   assign dm_re   = ex_mem.mem_re;

endmodule

// ==== src/writeback_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// writeback stage
// MEM/WB register, register write data select and sticky halt flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module writeback_stage (
   input  logic                   clk,
   input  logic                   rst,
   ex_mem_if.writeback            ex_mem,
   input  cpu_isa_pkg::word_t     dm_rdata,
   output logic                   rf_we,
   output logic                   halted,
   output cpu_isa_pkg::reg_addr_t rf_waddr,
   output cpu_isa_pkg::word_t     rf_wdata
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   wb_src_t src_q;
   word_t   alu_q;
   word_t   byte_q;
   word_t   rdata_q;

   // control
   always_ff @(posedge clk) begin
      if (rst) begin
         rf_we  <= 1'b0;
         halted <= 1'b0;
      end else begin
         rf_we <= ex_mem.reg_we;
         // stays up until reset
         if (ex_mem.halt) begin
            halted <= 1'b1;
         end
      end
   end

   // payload, read data only captured on a load
   always_ff @(posedge clk) begin
      rf_waddr <= ex_mem.rd;
      src_q    <= ex_mem.wb_src;
      alu_q    <= ex_mem.alu_out;
      byte_q   <= ex_mem.byte_data;
      if (ex_mem.mem_re) begin
         rdata_q <= dm_rdata;
      end
   end

   // write data select
   always_comb begin
      case (src_q)
         WB_MEM:  rf_wdata = rdata_q;
         WB_BYTE: rf_wdata = byte_q;
         default: rf_wdata = alu_q;
      endcase
   end

endmodule

// ==== src/cpu_core.sv ====
////////////////////////////////////////////////////////////////////////////
// 16-bit five-stage pipelined core
// fetch, decode, execute and writeback around the register file
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_core (
   input  logic                   clk,
   input  logic                   rst,
   input  cpu_isa_pkg::word_t     instr,
   input  cpu_isa_pkg::word_t     dm_rdata,
   output cpu_isa_pkg::word_t     pc,
   output cpu_isa_pkg::word_t     dm_addr,
   output cpu_isa_pkg::word_t     dm_wdata,
   output logic                   dm_we,
   output logic                   dm_re,
   output logic                   rf_we,
   output logic                   halted,
   output cpu_isa_pkg::reg_addr_t rf_waddr,
   output cpu_isa_pkg::word_t     rf_wdata
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   word_t     if_instr;
   logic      if_valid;
   logic      stall;
   logic      halt_seen;
   reg_addr_t rd_addr_a;
   reg_addr_t rd_addr_b;
   word_t     rd_data_a;
   word_t     rd_data_b;
   id_ex_t    id_ex;

   ex_mem_if ex_mem ();

   fetch_unit u_fetch (
      .clk       (clk),
      .rst       (rst),
      .instr     (instr),
      .stall     (stall),
      .halt_seen (halt_seen),
      .pc        (pc),
      .if_instr  (if_instr),
      .if_valid  (if_valid)
   );

   decode_stage u_decode (
      .clk       (clk),
      .rst       (rst),
      .if_instr  (if_instr),
      .if_valid  (if_valid),
      .ex_mem    (ex_mem.hazard),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .stall     (stall),
      .halt_seen (halt_seen),
      .id_ex     (id_ex)
   );

   // written from mem/wb, read from decode
   reg_file u_regs (
      .clk       (clk),
      .rst       (rst),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .we        (rf_we),
      .waddr     (rf_waddr),
      .wdata     (rf_wdata)
   );

   execute_stage u_execute (
      .clk      (clk),
      .rst      (rst),
      .id_ex    (id_ex),
      .ex_mem   (ex_mem.execute),
      .dm_addr  (dm_addr),
      .dm_wdata (dm_wdata),
      .dm_we    (dm_we),
      .dm_re    (dm_re)
   );

   writeback_stage u_writeback (
      .clk      (clk),
      .rst      (rst),
      .ex_mem   (ex_mem.writeback),
      .dm_rdata (dm_rdata),
      .rf_we    (rf_we),
      .halted   (halted),
      .rf_waddr (rf_waddr),
      .rf_wdata (rf_wdata)
   );

endmodule

// ==== sim/cpu_core_asserts.sv ====
////////////////////////////////////////////////////////////////////////////
// pipeline rule checks for the core
// memory strobes, writes after halt and the sticky halt flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_core_asserts (
   input logic clk,
   input logic rst,
   input logic dm_we,
   input logic dm_re,
   input logic rf_we,
   input logic halted
);

   // a data access is either a load or a store
   a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(dm_we && dm_re))
      else $error("dm_we and dm_re high in the same cycle");

   // only bubbles behind hlt
   a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
      $past(halted) |-> !rf_we)
      else $error("rf_we high after halted");

   // cleared by reset only
   a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
      else $error("halted fell without reset");

endmodule

// strobes live in execute, halt and register writes in writeback
bind execute_stage cpu_core_asserts u_ex_asserts (
   .clk    (clk),
   .rst    (rst),
   .dm_we  (dm_we),
   .dm_re  (dm_re),
   .rf_we  (1'b0),
   .halted (1'b0)
);

bind writeback_stage cpu_core_asserts u_wb_asserts (
   .clk    (clk),
   .rst    (rst),
   .dm_we  (1'b0),
   .dm_re  (1'b0),
   .rf_we  (rf_we),
   .halted (halted)
);

// ==== sim/tb_cpu_core.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the 16-bit pipelined core
// random programs run on the DUT and on an in-order model
// register writes and stores compared in order against the model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_cpu_core;
   import cpu_isa_pkg::*;

   localparam int          CLK_PERIOD      = 8;
   localparam int          RESET_CYCLES    = 16;
   localparam int          ROM_DEPTH       = 64;
   localparam int          PROG_LEN        = 32;
   localparam int          PROGS_PER_TEST  = 4;
   localparam int          NUM_PROGS       = 5 * PROGS_PER_TEST;
   localparam int          WATCHDOG_CYCLES = NUM_PROGS * PROG_LEN * 4 + 200;
   localparam logic [31:0] SEED            = 32'hefcc_7bf7;
   localparam word_t       HLT_WORD        = 16'hf000;

   // program kinds
   localparam int K_ALU  = 0;
   localparam int K_MEM  = 1;
   localparam int K_BYTE = 2;
   localparam int K_HAZ  = 3;
   localparam int K_HALT = 4;

   logic      clk;
   logic      rst;
   word_t     instr;
   word_t     dm_rdata;
   word_t     pc;
   word_t     dm_addr;
   word_t     dm_wdata;
   logic      dm_we;
   logic      dm_re;
   logic      rf_we;
   logic      halted;
   reg_addr_t rf_waddr;
   word_t     rf_wdata;

   word_t       rom  [ROM_DEPTH];
   word_t       dmem [256];
   word_t       mmem [256];
   // expected register writes and stores as {addr, data}
   logic [19:0] exp_rf [$];
   logic [31:0] exp_st [$];
   int          exp_ld;
   int          errors;
   int          checks;
   int          prog_rf;
   int          prog_st;
   int          prog_ld;
   int          tot_rf;
   int          tot_st;
   logic        was_halted;

   cpu_core uut (
      .clk      (clk),
      .rst      (rst),
      .instr    (instr),
      .dm_rdata (dm_rdata),
      .pc       (pc),
      .dm_addr  (dm_addr),
      .dm_wdata (dm_wdata),
      .dm_we    (dm_we),
      .dm_re    (dm_re),
      .rf_we    (rf_we),
      .halted   (halted),
      .rf_waddr (rf_waddr),
      .rf_wdata (rf_wdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // rom past the program reads as hlt
   assign instr    = (pc < 16'(ROM_DEPTH)) ? rom[pc[5:0]] : HLT_WORD;
   assign dm_rdata = dmem[dm_addr[7:0]];

   // both bytes follow the full address
   function automatic word_t fill_word(input logic [7:0] a);
      return {a ^ 8'hc3, ~a};
   endfunction

   // data memory refilled by every reset
   always @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(8'(i));
         end
      end else if (dm_we) begin
         dmem[dm_addr[7:0]] <= dm_wdata;
      end
   end

   task automatic check_value(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED %0d ns: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         $display("at %0d ns: %s", $time, what);
         errors++;
      end
   endtask

   function automatic word_t encode(input opcode_t op, input reg_addr_t rd,
                                    input reg_addr_t rs, input reg_addr_t rt);
      return {op, rd, rs, rt};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // program generator
   ////////////////////////////////////////////////////////////////////////////
   function automatic opcode_t pick_op(input int kind, input int sel);
      opcode_t op;
      op = OP_ADD;
      case (kind)
         K_ALU: begin
            case (sel % 5)
               1: op = OP_SUB;
               2: op = OP_AND;
               3: op = OP_NOR;
               4: op = OP_ADDI;
               default: ;
            endcase
         end
         K_MEM: begin
            case (sel % 4)
               0: op = OP_LW;
               1: op = OP_SW;
               2: op = OP_ADDI;
               default: ;
            endcase
         end
         K_BYTE: begin
            case (sel % 3)
               0: op = OP_LHB;
               1: op = OP_LLB;
               default: ;
            endcase
         end
         // hazard and halt programs mix every kept opcode
         default: begin
            case (sel % 9)
               1: op = OP_SUB;
               2: op = OP_AND;
               3: op = OP_NOR;
               4: op = OP_ADDI;
               5: op = OP_LW;
               6: op = OP_SW;
               7: op = OP_LHB;
               8: op = OP_LLB;
               default: ;
            endcase
         end
      endcase
      return op;
   endfunction

   function automatic word_t random_instr(input int kind, input logic [31:0] r);
      opcode_t   op;
      reg_addr_t rd;
      reg_addr_t rs;
      reg_addr_t rt;
      word_t     w;
      op = pick_op(kind, int'(r[31:24]));
      rd = r[11:8];
      rs = r[7:4];
      rt = r[3:0];
      // only r0..r2 so most instructions lean on the one before
      if (kind == K_HAZ) begin
         rd = 4'(int'(r[11:8]) % 3);
         rs = 4'(int'(r[7:4]) % 3);
         rt = 4'(int'(r[3:0]) % 3);
      end
      w = encode(op, rd, rs, rt);
      // small offsets so loads hit earlier stores
      if (kind == K_MEM && (op == OP_LW || op == OP_SW)) begin
         w[7:0] = {{5{r[2]}}, r[2:0]};
      end
      return w;
   endfunction

   task automatic gen_program(input int kind);
      logic [31:0] r;
      int          halt_at;
      for (int i = 0; i < ROM_DEPTH; i++) begin
         rom[i] = HLT_WORD;
      end
      // base register low byte then high byte
      r       = $urandom();
      rom[0]  = encode(OP_LLB, BASE_REG, r[7:4], r[3:0]);
      rom[1]  = encode(OP_LHB, BASE_REG, r[15:12], r[11:8]);
      // early hlt with live code behind it
      halt_at = (kind == K_HALT) ? 6 + int'(r[19:16]) : PROG_LEN - 1;
      for (int i = 2; i < PROG_LEN; i++) begin
         r      = $urandom();
         rom[i] = (i == halt_at) ? HLT_WORD : random_instr(kind, r);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // reference model stepping one instruction at a time
   ////////////////////////////////////////////////////////////////////////////
   task automatic run_model();
      word_t     regs [16];
      word_t     w;
      word_t     a;
      word_t     v;
      reg_addr_t rd;
      opcode_t   op;
      logic      done;
      exp_rf.delete();
      exp_st.delete();
      exp_ld = 0;
      for (int i = 0; i < 16; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         mmem[i] = fill_word(8'(i));
      end
      done = 1'b0;
      for (int p = 0; p < ROM_DEPTH && !done; p++) begin
         w  = rom[p];
         op = opcode_t'(w[15:12]);
         rd = w[11:8];
         v  = regs[rd];
         // r14 plus signed 8-bit offset
         a  = regs[BASE_REG] + {{8{w[7]}}, w[7:0]};
         case (op)
            OP_ADD:  v = regs[w[7:4]] + regs[w[3:0]];
            OP_SUB:  v = regs[w[7:4]] - regs[w[3:0]];
            OP_AND:  v = regs[w[7:4]] & regs[w[3:0]];
            OP_NOR:  v = ~(regs[w[7:4]] | regs[w[3:0]]);
            OP_ADDI: v = regs[w[7:4]] + {{12{w[3]}}, w[3:0]};
            OP_LW: begin
               v = mmem[a[7:0]];
               exp_ld++;
            end
            OP_LHB:  v = {w[7:0], regs[rd][7:0]};
            OP_LLB:  v = {regs[rd][15:8], w[7:0]};
            OP_SW: begin
               exp_st.push_back({a, regs[rd]});
               mmem[a[7:0]] = regs[rd];
            end
            OP_HLT:  done = 1'b1;
            default: ;
         endcase
         if (op <= OP_ADDI || op == OP_LW || op == OP_LHB || op == OP_LLB) begin
            exp_rf.push_back({rd, v});
            regs[rd] = v;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // running and watching the DUT
   ////////////////////////////////////////////////////////////////////////////
   task automatic hold_reset();
      @(negedge clk);
      rst = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
   endtask

   // one cycle with outputs sampled mid-cycle
   task automatic observe_cycle();
      logic [19:0] e;
      logic [31:0] s;
      @(negedge clk);
      if (rf_we) begin
         check_true(!was_halted, "register write after halted rose");
         check_true(exp_rf.size() > 0, "register write beyond the model's sequence");
         if (exp_rf.size() > 0) begin
            e = exp_rf.pop_front();
            check_value("rf_waddr", {12'd0, rf_waddr}, {12'd0, e[19:16]});
            check_value("rf_wdata", rf_wdata, e[15:0]);
         end
         prog_rf++;
      end
      if (dm_we) begin
         check_true(!was_halted, "store after halted rose");
         check_true(exp_st.size() > 0, "store beyond the model's sequence");
         if (exp_st.size() > 0) begin
            s = exp_st.pop_front();
            check_value("dm_addr", dm_addr, s[31:16]);
            check_value("dm_wdata", dm_wdata, s[15:0]);
         end
         prog_st++;
      end
      if (dm_re) begin
         check_true(!was_halted, "load after halted rose");
         prog_ld++;
      end
      if (halted) begin
         was_halted = 1'b1;
      end
   endtask

   task automatic run_program(input int kind);
      int m_rf;
      int m_st;
      hold_reset();
      gen_program(kind);
      run_model();
      m_rf       = exp_rf.size();
      m_st       = exp_st.size();
      prog_rf    = 0;
      prog_st    = 0;
      prog_ld    = 0;
      was_halted = 1'b0;
      rst        = 1'b0;
      while (!halted) begin
         observe_cycle();
      end
      // quiet window after halt
      repeat (8) observe_cycle();
      check_true(prog_rf == m_rf, "register write count differs from the model");
      check_true(prog_st == m_st, "store count differs from the model");
      check_true(prog_ld == exp_ld, "load strobe count differs from the model");
      tot_rf += prog_rf;
      tot_st += prog_st;
   endtask

   task automatic run_test(input int num, input string name, input int kind);
      int errs0;
      errs0  = errors;
      tot_rf = 0;
      tot_st = 0;
      for (int n = 0; n < PROGS_PER_TEST; n++) begin
         run_program(kind);
      end
      $display("test %0d %s: %0d programs, %0d register writes, %0d stores, %0d errors",
               num, name, PROGS_PER_TEST, tot_rf, tot_st, errors - errs0);
   endtask

   task automatic test_reset();
      int errs0;
      errs0 = errors;
      hold_reset();
      check_value("pc", pc, 16'h0000);
      check_value("rf_we", {15'd0, rf_we}, 16'h0000);
      check_value("dm_we", {15'd0, dm_we}, 16'h0000);
      check_value("dm_re", {15'd0, dm_re}, 16'h0000);
      check_value("halted", {15'd0, halted}, 16'h0000);
      rst = 1'b0;
      $display("test 1 reset: %0d errors", errors - errs0);
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      errors     = 0;
      checks     = 0;
      was_halted = 1'b0;
      for (int i = 0; i < ROM_DEPTH; i++) begin
         rom[i] = HLT_WORD;
      end
      void'($urandom(SEED));
      test_reset();
      run_test(2, "alu ops", K_ALU);
      run_test(3, "memory", K_MEM);
      run_test(4, "byte loads", K_BYTE);
      run_test(5, "hazards", K_HAZ);
      run_test(6, "halt", K_HALT);
      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // worst case about three cycles per instruction with every stall
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, halted never reached", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== tb.f ====
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/ex_mem_if.sv
src/fetch_unit.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/writeback_stage.sv
src/cpu_core.sv
sim/cpu_core_asserts.sv
sim/tb_cpu_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_cpu_core
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found
SHELL     := /bin/bash

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	set -o pipefail; ./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
